// File: logic/ls_pkg.sv
// load/store unit shared definitions
// widths, instruction id type and the access encodings
// used by the unit, its sub-units and the testbench

package ls_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths

    // data and address width
    localparam int XLEN = 32;

    // instruction id width
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    ////////////////////////////////////////////////////////////////////////////
    // access encodings

    // low two bits of fn3
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } ls_size_e;

    // riscv load/store fn3
    // stores only use fn_b, fn_h and fn_w
    typedef enum logic [2:0] {
        fn_b  = 3'b000,
        fn_h  = 3'b001,
        fn_w  = 3'b010,
        fn_bu = 3'b100,
        fn_hu = 3'b101
    } ls_fn3_e;

    ////////////////////////////////////////////////////////////////////////////
    // sub-unit select

    // scratch below the scratch limit, bus above
    typedef enum logic {
        unit_scratch = 1'b0,
        unit_bus     = 1'b1
    } subunit_e;

endpackage

// File: logic/load_attr_fifo.sv
// load attribute FIFO
// small synchronous circular buffer for in-flight load attributes,
// oldest entry always shown on data_out

`timescale 1ns/1ps

module load_attr_fifo #(
    parameter int DEPTH = 2,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // storage, no reset needed on payload
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    // pointers wrap at DEPTH, so non power of two depths work too
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // push with pop keeps occupancy
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

// File: logic/scratch_ram.sv
// scratch RAM sub-unit
// word-wide on-chip memory with byte enables,
// registered read data one cycle after the request

`timescale 1ns/1ps

module scratch_ram #(
    parameter int WORDS = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  logic                    we,
    input  logic [ls_pkg::XLEN-1:0] addr,
    input  logic [ls_pkg::XLEN-1:0] wdata,
    input  logic [3:0]              be,
    output logic                    unit_ready,
    output logic                    data_valid,
    output logic [ls_pkg::XLEN-1:0] rdata
);

    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [ls_pkg::XLEN-1:0] mem [WORDS];
    logic [AW-1:0]           word_idx;

    // word index from the byte address
    assign word_idx = addr[AW+1:2];

    // byte-lane writes, only enabled lanes change
    always_ff @(posedge clk) begin
        if (new_request && we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i])
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (new_request && !we)
            rdata <= mem[word_idx];
    end

    // read strobe and ready flag
    // ready comes up one cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
            unit_ready <= 1'b0;
        end else begin
            data_valid <= new_request && !we;
            unit_ready <= 1'b1;
        end
    end

endmodule

// File: logic/bus_port.sv
// external bus port sub-unit
// req/ack master, one transaction at a time, request captured
// into registers and held until the ack

`timescale 1ns/1ps

module bus_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  logic                    we,
    input  logic [ls_pkg::XLEN-1:0] addr,
    input  logic [ls_pkg::XLEN-1:0] wdata,
    input  logic [3:0]              be,
    output logic                    unit_ready,
    output logic                    data_valid,
    output logic [ls_pkg::XLEN-1:0] rdata,
    output logic                    store_ack,
    output logic                    bus_req,
    output logic                    bus_we,
    output logic [ls_pkg::XLEN-1:0] bus_addr,
    output logic [ls_pkg::XLEN-1:0] bus_wdata,
    output logic [3:0]              bus_be,
    input  logic                    bus_ack,
    input  logic [ls_pkg::XLEN-1:0] bus_rdata
);

    typedef enum logic {
        st_idle,
        st_wait
    } bus_state_e;

    bus_state_e state;

    ////////////////////////////////////////////////////////////////////////////
    // control FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            data_valid <= 1'b0;
            store_ack  <= 1'b0;
        end else begin
            // completion pulses, one cycle after the ack
            data_valid <= (state == st_wait) && bus_ack && !bus_we;
            store_ack  <= (state == st_wait) && bus_ack && bus_we;
            case (state)
                st_idle: if (new_request) state <= st_wait;
                st_wait: if (bus_ack) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request and response registers

    // fields held stable while req is high
    always_ff @(posedge clk) begin
        if (state == st_idle && new_request) begin
            bus_we    <= we;
            bus_addr  <= {addr[ls_pkg::XLEN-1:2], 2'b00};
            bus_wdata <= wdata;
            bus_be    <= be;
        end
        // read data only valid in the ack cycle
        if (state == st_wait && bus_ack && !bus_we)
            rdata <= bus_rdata;
    end

    assign bus_req    = (state == st_wait);
    assign unit_ready = (state == st_idle);

endmodule

// File: logic/load_store_unit.sv
// load/store unit
// effective address, store byte enables, sub-unit select between
// scratch RAM and external bus, unit-switch stall, load alignment
// with sign/zero extension and writeback

`timescale 1ns/1ps

module load_store_unit #(
    parameter int SCRATCH_WORDS = 256,
    parameter int ATTR_DEPTH    = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    // issue side
    input  logic                    issue_valid,
    input  logic                    is_load,
    input  logic                    is_store,
    input  ls_pkg::ls_fn3_e         fn3,
    input  logic [ls_pkg::XLEN-1:0] rs1,
    input  logic [11:0]             offset,
    input  logic [ls_pkg::XLEN-1:0] rs2,
    input  ls_pkg::id_t             issue_id,
    output logic                    issue_ready,
    // load writeback
    output logic                    wb_done,
    output logic [ls_pkg::XLEN-1:0] wb_data,
    output ls_pkg::id_t             wb_id,
    // store completion
    output logic                    store_done,
    output ls_pkg::id_t             store_id,
    // external bus
    output logic                    bus_req,
    output logic                    bus_we,
    output logic [ls_pkg::XLEN-1:0] bus_addr,
    output logic [ls_pkg::XLEN-1:0] bus_wdata,
    output logic [3:0]              bus_be,
    input  logic                    bus_ack,
    input  logic [ls_pkg::XLEN-1:0] bus_rdata
);

    // byte addresses below this go to scratch
    localparam logic [ls_pkg::XLEN-1:0] SCRATCH_LIMIT = SCRATCH_WORDS * 4;

    // attributes kept per outstanding load
    typedef struct packed {
        ls_pkg::ls_fn3_e  fn3;
        logic [1:0]       byte_addr;
        ls_pkg::id_t      id;
        ls_pkg::subunit_e unit;
    } load_attr_t;

    logic [ls_pkg::XLEN-1:0] addr;
    ls_pkg::ls_size_e        size;
    logic [3:0]              be;
    ls_pkg::subunit_e        target;
    ls_pkg::subunit_e        last_unit;
    logic                    accept;
    logic                    switch_stall;
    logic                    full_stall;
    logic                    load_complete;
    logic                    scratch_store_done;

    load_attr_t attr_in;
    load_attr_t attr_head;
    logic       attr_valid;
    logic       attr_full;

    logic                    scratch_new_request;
    logic                    scratch_ready;
    logic                    scratch_data_valid;
    logic [ls_pkg::XLEN-1:0] scratch_rdata;

    logic                    bus_new_request;
    logic                    bus_unit_ready;
    logic                    bus_data_valid;
    logic [ls_pkg::XLEN-1:0] bus_unit_rdata;
    logic                    bus_store_ack;

    logic [ls_pkg::XLEN-1:0] unit_data;
    logic [ls_pkg::XLEN-1:0] half_sel;
    logic [ls_pkg::XLEN-1:0] byte_sel;

    ////////////////////////////////////////////////////////////////////////////
    // address generation and byte enables

    // base plus sign extended 12-bit offset
    assign addr = rs1 + {{(ls_pkg::XLEN-12){offset[11]}}, offset};
    assign size = ls_pkg::ls_size_e'(fn3[1:0]);

    // one byte, a half, or the whole word
    always_comb begin
        be = 4'b0000;
        case (size)
            ls_pkg::size_byte: be[addr[1:0]] = 1'b1;
            ls_pkg::size_half: be = addr[1] ? 4'b1100 : 4'b0011;
            default:           be = 4'b1111;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // sub-unit select and issue control

    assign target = (addr < SCRATCH_LIMIT) ? ls_pkg::unit_scratch : ls_pkg::unit_bus;

    // no switching units with loads still in flight
    assign switch_stall = (target != last_unit) && attr_valid;
    // a pop this cycle frees a slot
    assign full_stall   = attr_full && !load_complete;

    assign issue_ready = scratch_ready && bus_unit_ready && !switch_stall && !full_stall;
    assign accept      = issue_valid && issue_ready && (is_load || is_store);

    assign scratch_new_request = accept && (target == ls_pkg::unit_scratch);
    assign bus_new_request     = accept && (target == ls_pkg::unit_bus);

    // sub-unit of the most recent load
    always_ff @(posedge clk) begin
        if (rst)
            last_unit <= ls_pkg::unit_scratch;
        else if (accept && is_load)
            last_unit <= target;
    end

    ////////////////////////////////////////////////////////////////////////////
    // load attributes

    assign attr_in.fn3       = fn3;
    assign attr_in.byte_addr = addr[1:0];
    assign attr_in.id        = issue_id;
    assign attr_in.unit      = target;

    load_attr_fifo #(
        .DEPTH(ATTR_DEPTH),
        .WIDTH($bits(load_attr_t))
    ) load_attr_fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .push     (accept && is_load),
        .pop      (load_complete),
        .data_in  (attr_in),
        .data_out (attr_head),
        .valid    (attr_valid),
        .full     (attr_full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // sub-units

    scratch_ram #(
        .WORDS(SCRATCH_WORDS)
    ) scratch_ram_inst (
        .clk         (clk),
        .rst         (rst),
        .new_request (scratch_new_request),
        .we          (is_store),
        .addr        (addr),
        .wdata       (rs2),
        .be          (be),
        .unit_ready  (scratch_ready),
        .data_valid  (scratch_data_valid),
        .rdata       (scratch_rdata)
    );

    bus_port bus_port_inst (
        .clk         (clk),
        .rst         (rst),
        .new_request (bus_new_request),
        .we          (is_store),
        .addr        (addr),
        .wdata       (rs2),
        .be          (be),
        .unit_ready  (bus_unit_ready),
        .data_valid  (bus_data_valid),
        .rdata       (bus_unit_rdata),
        .store_ack   (bus_store_ack),
        .bus_req     (bus_req),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_be      (bus_be),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // load return path

    assign load_complete = scratch_data_valid || bus_data_valid;
    // head of the FIFO says who answers
    assign unit_data = (attr_head.unit == ls_pkg::unit_bus) ? bus_unit_rdata : scratch_rdata;

    // halfword first, then byte, aligned accesses only
    assign half_sel = attr_head.byte_addr[1] ? {unit_data[31:16], unit_data[31:16]} : unit_data;
    assign byte_sel = {half_sel[31:8], attr_head.byte_addr[0] ? half_sel[15:8] : half_sel[7:0]};

    // sign or zero extension
    always_comb begin
        case (attr_head.fn3)
            ls_pkg::fn_b:  wb_data = {{24{byte_sel[7]}}, byte_sel[7:0]};
            ls_pkg::fn_h:  wb_data = {{16{byte_sel[15]}}, byte_sel[15:0]};
            ls_pkg::fn_bu: wb_data = {24'h0, byte_sel[7:0]};
            ls_pkg::fn_hu: wb_data = {16'h0, byte_sel[15:0]};
            default:       wb_data = byte_sel;
        endcase
    end

    assign wb_done = load_complete;
    assign wb_id   = attr_head.id;

    ////////////////////////////////////////////////////////////////////////////
    // store completion

    // scratch write lands at the accept edge, done the cycle after
    always_ff @(posedge clk) begin
        if (rst)
            scratch_store_done <= 1'b0;
        else
            scratch_store_done <= scratch_new_request && is_store;
    end

    // id of last accepted store
    always_ff @(posedge clk) begin
        if (accept && is_store)
            store_id <= issue_id;
    end

    assign store_done = scratch_store_done || bus_store_ack;

endmodule

// File: verif/ls_tb_properties.sv
// load/store unit properties
// issue handshake, alignment, writeback and bus request checks

`timescale 1ns/1ps

module ls_tb_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    accept,
    input ls_pkg::subunit_e        target,
    input ls_pkg::subunit_e        head_unit,
    input ls_pkg::ls_fn3_e         fn3,
    input logic [ls_pkg::XLEN-1:0] addr,
    input logic                    wb_done,
    input logic                    attr_valid,
    input logic                    bus_req,
    input logic                    bus_ack,
    input logic                    bus_we,
    input logic [ls_pkg::XLEN-1:0] bus_addr,
    input logic [ls_pkg::XLEN-1:0] bus_wdata,
    input logic [3:0]              bus_be
);

    // nothing accepted during a bus access or across a unit switch
    accept_when_free: assert property (@(posedge clk) disable iff (rst)
        accept |-> !bus_req && (!attr_valid || target == head_unit))
        else $error("request accepted while issue was stalled");

    // halves on even bytes, words on word boundaries
    aligned_access: assert property (@(posedge clk) disable iff (rst)
        accept |-> !((fn3[1:0] == 2'b01 && addr[0]) || (fn3[1:0] == 2'b10 && addr[1:0] != 2'b00)))
        else $error("misaligned access issued");

    // every result needs an outstanding load
    wb_needs_load: assert property (@(posedge clk) disable iff (rst)
        wb_done |-> attr_valid) else $error("wb_done with attribute FIFO empty");

    // request held with stable fields until ack
    bus_fields_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_req && !bus_ack) |=> bus_req && $stable(bus_we) && $stable(bus_addr)
            && $stable(bus_wdata) && $stable(bus_be))
        else $error("bus request changed before ack");

endmodule

bind load_store_unit ls_tb_properties ls_tb_properties_inst (
    .clk         (clk),
    .rst         (rst),
    .accept      (accept),
    .target      (target),
    .head_unit   (attr_head.unit),
    .fn3         (fn3),
    .addr        (addr),
    .wb_done     (wb_done),
    .attr_valid  (attr_valid),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .bus_we      (bus_we),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_be      (bus_be)
);

// File: verif/ls_tb.sv
// load/store unit testbench
// directed tests with a bus responder, reference memories,
// result monitor and watchdog

`timescale 1ns/1ps

module ls_tb;

    localparam int SCRATCH_WORDS = 256;
    localparam int N_TESTS       = 6;
    localparam logic [31:0] BUS_BASE = 32'h0000_8000;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid, is_load, is_store;
    ls_pkg::ls_fn3_e fn3;
    logic [31:0] rs1, rs2;
    logic [11:0] offset;
    ls_pkg::id_t issue_id;
    logic issue_ready, wb_done, store_done;
    logic [31:0] wb_data;
    ls_pkg::id_t wb_id, store_id;
    logic bus_req, bus_we, bus_ack;
    logic [31:0] bus_addr, bus_wdata, bus_rdata;
    logic [3:0] bus_be;

    int errors = 0;
    int cyc = 0;
    int dly;
    ls_pkg::id_t next_id = '0;

    // reference memories, byte addressed
    logic [7:0] sc_ref [logic [31:0]];
    logic [7:0] bus_mem [logic [31:0]];

    // expected results in issue order
    logic [31:0] exp_data [$];
    ls_pkg::id_t exp_id [$];
    int          exp_cyc [$];
    ls_pkg::id_t exp_sid [$];
    logic [31:0] bq_addr [$];
    logic [31:0] bq_data [$];
    logic [3:0]  bq_be [$];
    logic        bq_we [$];

    load_store_unit #(.SCRATCH_WORDS(SCRATCH_WORDS), .ATTR_DEPTH(2)) load_store_unit_inst (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // watchdog, 200 cycles per test
    initial begin
        #(N_TESTS * 200 * 20);
        $display("timeout: run did not finish in time");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and reference model

    task automatic check_word(input string name, input logic [ls_pkg::XLEN-1:0] got,
                              input logic [ls_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input ls_pkg::id_t got, input ls_pkg::id_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // unwritten bus bytes follow a pattern of the whole address
    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        if (a < SCRATCH_WORDS * 4)
            return sc_ref.exists(a) ? sc_ref[a] : 8'hxx;
        if (bus_mem.exists(a))
            return bus_mem[a];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    // aligned, shifted and extended load value
    function automatic logic [31:0] load_value(input logic [31:0] a, input ls_pkg::ls_fn3_e f);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = ref_byte({a[31:2], 2'b00} + i);
        w = w >> (8 * a[1:0]);
        case (f)
            ls_pkg::fn_b:  return {{24{w[7]}}, w[7:0]};
            ls_pkg::fn_bu: return {24'h0, w[7:0]};
            ls_pkg::fn_h:  return {{16{w[15]}}, w[15:0]};
            ls_pkg::fn_hu: return {16'h0, w[15:0]};
            default:       return w;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus responder, 0 to 3 wait cycles

    always @(posedge clk) begin
        if (rst || bus_ack) begin
            bus_ack <= 1'b0;
        end else if (bus_req) begin
            if (dly == 0) begin
                if (bq_addr.size() == 0) begin
                    errors++;
                    $display("bus request without a matching access");
                end else begin
                    check_word("bus_addr", bus_addr, bq_addr.pop_front());
                    check_be("bus_be", bus_be, bq_be.pop_front());
                    check_word("bus_we", 32'(bus_we), 32'(bq_we.pop_front()));
                    if (bus_we)
                        check_word("bus_wdata", bus_wdata, bq_data.pop_front());
                    else
                        void'(bq_data.pop_front());
                end
                for (int i = 0; i < 4; i++) begin
                    if (bus_we && bus_be[i])
                        bus_mem[bus_addr + i] = bus_wdata[8*i +: 8];
                    bus_rdata[8*i +: 8] <= ref_byte(bus_addr + i);
                end
                bus_ack <= 1'b1;
                dly = $urandom % 4;
            end else begin
                dly = dly - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result monitor

    always @(negedge clk) begin
        if (!rst && wb_done) begin
            if (exp_id.size() == 0) begin
                errors++;
                $display("load result with no load outstanding");
            end else begin
                check_word("wb_data", wb_data, exp_data.pop_front());
                check_id("wb_id", wb_id, exp_id.pop_front());
                // scratch loads complete the cycle after acceptance
                if (exp_cyc[0] >= 0 && exp_cyc[0] != cyc) begin
                    errors++;
                    $display("scratch load result not one cycle after acceptance");
                end
                void'(exp_cyc.pop_front());
            end
        end
        if (!rst && store_done) begin
            if (exp_sid.size() == 0) begin
                errors++;
                $display("store completion with no store outstanding");
            end else begin
                check_id("store_id", store_id, exp_sid.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // issue helpers

    // called at a rising edge, returns at the acceptance edge
    task automatic send(input bit ld, input ls_pkg::ls_fn3_e f, input logic [31:0] base,
                        input logic [11:0] off, input logic [31:0] data);
        logic [31:0] a;
        logic [3:0]  b;
        logic        rdy;
        a = base + {{20{off[11]}}, off};
        case (f[1:0])
            2'b00:   b = 4'b0001 << a[1:0];
            2'b01:   b = a[1] ? 4'b1100 : 4'b0011;
            default: b = 4'b1111;
        endcase
        issue_valid <= 1'b1;
        is_load     <= ld;
        is_store    <= !ld;
        fn3         <= f;
        rs1         <= base;
        offset      <= off;
        rs2         <= data;
        issue_id    <= next_id;
        do begin
            @(negedge clk);
            rdy = issue_ready;
            @(posedge clk);
        end while (!rdy);
        if (ld) begin
            exp_data.push_back(load_value(a, f));
            exp_id.push_back(next_id);
            exp_cyc.push_back(a < SCRATCH_WORDS * 4 ? cyc + 1 : -1);
        end else begin
            exp_sid.push_back(next_id);
            if (a < SCRATCH_WORDS * 4)
                for (int i = 0; i < 4; i++)
                    if (b[i])
                        sc_ref[{a[31:2], 2'b00} + i] = data[8*i +: 8];
        end
        if (a >= SCRATCH_WORDS * 4) begin
            bq_addr.push_back({a[31:2], 2'b00});
            bq_be.push_back(b);
            bq_we.push_back(!ld);
            bq_data.push_back(data);
        end
        next_id++;
    endtask

    // drop valid, wait for all results, end on a rising edge
    task automatic drain;
        issue_valid <= 1'b0;
        is_load     <= 1'b0;
        is_store    <= 1'b0;
        while (exp_id.size() != 0 || exp_sid.size() != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    // ready stays low for the first cycle out of reset
    task automatic reset_state;
        @(negedge clk);
        if (wb_done || store_done || bus_req || issue_ready) begin
            errors++;
            $display("outputs not low after reset");
        end
        @(negedge clk);
        if (!issue_ready) begin
            errors++;
            $display("issue_ready did not rise one cycle after reset");
        end
        @(posedge clk);
    endtask

    task automatic scratch_word;
        send(0, ls_pkg::fn_w, 32'h40, 12'h0, 32'hdead_beef);
        send(1, ls_pkg::fn_w, 32'h40, 12'h0, 32'h0);
        drain();
    endtask

    task automatic scratch_sub_word;
        send(0, ls_pkg::fn_w, 32'h80, 12'h0, 32'h1122_3344);
        for (int o = 0; o < 4; o++)
            send(0, ls_pkg::fn_b, 32'h80, 12'(o), {4{8'h8c + 8'(o * 16)}});
        send(0, ls_pkg::fn_w, 32'h90, 12'h0, 32'h5566_7788);
        send(0, ls_pkg::fn_h, 32'h90, 12'h0, {2{16'h9a01}});
        send(0, ls_pkg::fn_h, 32'h90, 12'h2, {2{16'h1234}});
        for (int o = 0; o < 4; o++) begin
            send(1, ls_pkg::fn_b, 32'h80, 12'(o), 32'h0);
            send(1, ls_pkg::fn_bu, 32'h80, 12'(o), 32'h0);
            send(1, ls_pkg::fn_b, 32'h90, 12'(o), 32'h0);
        end
        for (int o = 0; o < 4; o += 2) begin
            send(1, ls_pkg::fn_h, 32'h90, 12'(o), 32'h0);
            send(1, ls_pkg::fn_hu, 32'h90, 12'(o), 32'h0);
        end
        send(1, ls_pkg::fn_w, 32'h80, 12'h0, 32'h0);
        drain();
    endtask

    task automatic bus_access;
        send(0, ls_pkg::fn_w, BUS_BASE, 12'h10, 32'hcafe_f00d);
        send(0, ls_pkg::fn_b, BUS_BASE, 12'h13, {4{8'hf1}});
        send(0, ls_pkg::fn_h, BUS_BASE, 12'h16, {2{16'h8abc}});
        send(1, ls_pkg::fn_w, BUS_BASE, 12'h10, 32'h0);
        send(1, ls_pkg::fn_b, BUS_BASE, 12'h13, 32'h0);
        send(1, ls_pkg::fn_bu, BUS_BASE, 12'h13, 32'h0);
        send(1, ls_pkg::fn_h, BUS_BASE, 12'h16, 32'h0);
        send(1, ls_pkg::fn_hu, BUS_BASE, 12'h16, 32'h0);
        // negative offset back onto the stored word
        send(1, ls_pkg::fn_w, BUS_BASE + 32'h20, 12'hff0, 32'h0);
        send(1, ls_pkg::fn_w, BUS_BASE, 12'h24, 32'h0);
        drain();
    endtask

    task automatic scratch_stream;
        int start;
        start = cyc;
        for (int i = 0; i < 8; i++)
            send(1, (i % 2) ? ls_pkg::fn_w : ls_pkg::fn_bu, 32'h80, 12'(16 * (i % 2)), 32'h0);
        // one acceptance on every edge
        if (cyc - start != 8) begin
            errors++;
            $display("scratch loads did not issue on consecutive cycles");
        end
        drain();
    endtask

    task automatic unit_switch;
        send(1, ls_pkg::fn_w, 32'h40, 12'h0, 32'h0);
        send(1, ls_pkg::fn_b, 32'h80, 12'h1, 32'h0);
        send(1, ls_pkg::fn_w, BUS_BASE, 12'h10, 32'h0);
        send(1, ls_pkg::fn_h, 32'h90, 12'h2, 32'h0);
        send(1, ls_pkg::fn_w, 32'h40, 12'h0, 32'h0);
        send(1, ls_pkg::fn_hu, BUS_BASE, 12'h16, 32'h0);
        send(1, ls_pkg::fn_w, 32'h80, 12'h0, 32'h0);
        drain();
    endtask

    initial begin
        void'($urandom(32'h889c_af37));
        dly         = $urandom % 4;
        rst         = 1'b1;
        issue_valid = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        fn3         = ls_pkg::fn_w;
        rs1         = '0;
        rs2         = '0;
        offset      = '0;
        issue_id    = '0;
        bus_ack     = 1'b0;
        bus_rdata   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        scratch_word();
        scratch_sub_word();
        bus_access();
        scratch_stream();
        unit_switch();
        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: src.f
logic/ls_pkg.sv
logic/load_attr_fifo.sv
logic/scratch_ram.sv
logic/bus_port.sv
logic/load_store_unit.sv
verif/ls_tb_properties.sv
verif/ls_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module ls_tb -o ls_sim
./obj_dir/ls_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
